/* list.f */
+incdir+source
source/render_pkg.sv
source/sprite_layers.sv
source/pixel_fifo.sv
source/pixel_compositor.sv
source/goose_render_top.sv
sim/goose_render_sva.sv
sim/tb_goose_render.sv

/* sim/tb_goose_render.sv */
`include "render_defs.svh"

module tb_goose_render
    import render_pkg::*;
();

    localparam int N_SCENES       = 6;
    localparam int PIX_PER_SCENE  = 400;
    localparam int TIMEOUT_CYCLES = N_SCENES * PIX_PER_SCENE * 4 + 400;

    logic       clk;
    logic       sys_rst;
    logic       pix_valid;
    logic       pix_ready;
    coord_t     haddr;
    coord_t     vaddr;
    logic       display_on;
    logic [6:0] jump_pos;
    scroll_t    scroll_pos;
    logic [1:0] obstacle_select;
    logic [1:0] obstacle_type;
    logic       game_start_blink;
    logic       rgb_valid;
    logic       rgb_ready;
    chan_t      r;
    chan_t      g;
    chan_t      b;
    logic       collision;

    integer seed;
    int     cycles;
    int     sent;
    int     received;
    logic   took_pixel;
    int     win_goose_top;   // Sprite positions of the current scene, for aiming stimulus
    int     win_ion_left;
    int     win_uw_left;
    rgb_t   exp_rgb_q[$];
    logic   exp_hit_q[$];

    goose_render_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic stop_on_failure();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input string name);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got (%0d,%0d,%0d) expected (%0d,%0d,%0d)",
                     $time, name, got.r, got.g, got.b, exp.r, exp.g, exp.b);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // Reference model of the scene for one pixel
    task automatic predict(input coord_t h, input coord_t v, input logic de,
                           output rgb_t col, output logic hit);
        int   hi;
        int   vi;
        int   goose_top;
        int   ion_left;
        int   uw_left;
        int   dx;
        int   dy;
        logic in_goose;
        logic in_ion;
        logic in_uw;
        logic on_edge;
        hi        = int'(h);
        vi        = int'(v);
        goose_top = `RENDER_GOOSE_Y_BASE - int'(jump_pos);
        ion_left  = (`RENDER_OBS_START - int'(scroll_pos) + 2048) % 2048;
        uw_left   = (ion_left + `RENDER_UW_OFFSET) % 2048;
        dx        = hi - uw_left;
        dy        = vi - (`RENDER_FLOOR_Y - `RENDER_UW_H);

        in_goose = game_start_blink &&
                   hi >= `RENDER_GOOSE_X && hi < `RENDER_GOOSE_X + `RENDER_GOOSE_W &&
                   vi >= goose_top && vi < goose_top + `RENDER_GOOSE_H;
        in_ion = obstacle_select[0] &&
                 hi >= ion_left && hi < ion_left + `RENDER_ION_W &&
                 vi >= `RENDER_FLOOR_Y - `RENDER_ION_H && vi < `RENDER_FLOOR_Y &&
                 (obstacle_type[0] || (vi % 8) < 4);  // Dashed in groups of four rows
        on_edge = dx < `RENDER_UW_EDGE || dx >= `RENDER_UW_W - `RENDER_UW_EDGE ||
                  dy < `RENDER_UW_EDGE || dy >= `RENDER_UW_H - `RENDER_UW_EDGE;
        in_uw = obstacle_select[1] && dx >= 0 && dx < `RENDER_UW_W &&
                dy >= 0 && dy < `RENDER_UW_H && (obstacle_type[1] || on_edge);

        if (!de) begin
            col = '{2'd0, 2'd0, 2'd0};
        end else if (in_goose) begin
            col = '{2'd3, 2'd3, 2'd0};
        end else if (in_ion) begin
            col = '{2'd1, 2'd1, 2'd1};
        end else if (in_uw) begin
            col = '{2'd3, 2'd3, 2'd3};
        end else if (vi >= `RENDER_FLOOR_Y) begin
            col = '{2'd1, 2'd1, 2'd1};  // Ground
        end else begin
            col = '{2'd0, 2'd3, 2'd3};  // Sky
        end
        hit = de && in_goose && (in_ion || in_uw);
    endtask

    // Mostly aim at a sprite window so layers get hit
    task automatic pick_coord(output coord_t h, output coord_t v);
        case (pick(5))
            0: begin
                h = coord_t'(`RENDER_GOOSE_X - 8 + pick(`RENDER_GOOSE_W + 16));
                v = coord_t'(win_goose_top - 8 + pick(`RENDER_GOOSE_H + 16));
            end
            1: begin
                h = coord_t'(win_ion_left - 8 + pick(`RENDER_ION_W + 16));
                v = coord_t'(`RENDER_FLOOR_Y - `RENDER_ION_H - 8 + pick(`RENDER_ION_H + 16));
            end
            2: begin
                h = coord_t'(win_uw_left - 8 + pick(`RENDER_UW_W + 16));
                v = coord_t'(`RENDER_FLOOR_Y - `RENDER_UW_H - 8 + pick(`RENDER_UW_H + 16));
            end
            3: begin
                h = coord_t'(pick(640));
                v = coord_t'(`RENDER_FLOOR_Y - 8 + pick(16));  // Around the horizon
            end
            default: begin
                h = coord_t'(pick(640));
                v = coord_t'(pick(480));
            end
        endcase
    endtask

    task automatic set_scene(input int idx);
        int target;
        @(negedge clk);
        case (idx)
            0:       begin obstacle_select = 2'b00; obstacle_type = 2'b00; end
            1:       begin obstacle_select = 2'b01; obstacle_type = 2'b01; end
            2:       begin obstacle_select = 2'b10; obstacle_type = 2'b10; end
            3:       begin obstacle_select = 2'b11; obstacle_type = 2'b00; end
            4:       begin obstacle_select = 2'b11; obstacle_type = 2'b11; end
            default: begin obstacle_select = 2'b11; obstacle_type = 2'(pick(4)); end
        endcase
        game_start_blink = (idx != 0) && (idx != N_SCENES - 1);
        jump_pos = 7'(pick(48));
        target = 35 + pick(50);  // Left column near the goose
        if (idx == 2 || idx == 4) begin
            win_ion_left = (target - `RENDER_UW_OFFSET + 2048) % 2048;
        end else begin
            win_ion_left = target;
        end
        scroll_pos = scroll_t'(`RENDER_OBS_START - win_ion_left + 2048);
        win_goose_top = `RENDER_GOOSE_Y_BASE - int'(jump_pos);
        win_uw_left = (win_ion_left + `RENDER_UW_OFFSET) % 2048;
    endtask

    task automatic run_cycle(input logic allow_new);
        rgb_t   exp_col;
        logic   exp_hit;
        coord_t h;
        coord_t v;
        @(negedge clk);
        if (!pix_valid || took_pixel) begin
            pix_valid = 1'b0;
            if (allow_new && pick(2) == 1) begin
                pick_coord(h, v);
                haddr      = h;
                vaddr      = v;
                display_on = 1'(pick(2));
                pix_valid  = 1'b1;
            end
        end
        rgb_ready = 1'(pick(2));
        #1;
        if (rgb_valid && rgb_ready) begin
            if (exp_rgb_q.size() == 0) begin
                $display("Output transfer at %0t with no pixel outstanding", $time);
                stop_on_failure();
            end
            check_rgb(rgb_t'{r, g, b}, exp_rgb_q.pop_front(), "rgb");
            check_bit(collision, exp_hit_q.pop_front(), "collision");
            received++;
        end
        took_pixel = pix_valid && pix_ready;  // Transfer at the coming rising edge
        if (took_pixel) begin
            predict(haddr, vaddr, display_on, exp_col, exp_hit);
            exp_rgb_q.push_back(exp_col);
            exp_hit_q.push_back(exp_hit);
            sent++;
        end
    endtask

    initial begin
        int scene_sent;
        seed             = 32'h1f53_786f;
        cycles           = 0;
        sent             = 0;
        received         = 0;
        took_pixel       = 1'b0;
        sys_rst          = 1'b1;
        pix_valid        = 1'b0;
        haddr            = '0;
        vaddr            = '0;
        display_on       = 1'b0;
        jump_pos         = '0;
        scroll_pos       = '0;
        obstacle_select  = '0;
        obstacle_type    = '0;
        game_start_blink = 1'b0;
        rgb_ready        = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        sys_rst = 1'b0;

        for (int s = 0; s < N_SCENES; s++) begin
            set_scene(s);
            scene_sent = sent;
            while (sent - scene_sent < PIX_PER_SCENE) begin
                run_cycle(1'b1);
            end
            // Drain before the scene may change
            do begin
                run_cycle(1'b0);
            end while (pix_valid || exp_rgb_q.size() != 0);
        end

        // Last transfer has gone, nothing may remain in the pipeline
        @(negedge clk);
        if (rgb_valid) begin
            $display("Output still valid after all %0d pixels came out", received);
            stop_on_failure();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

/* sim/goose_render_sva.sv */
module goose_render_sva
    import render_pkg::*;
(
    input logic       clk,
    input logic       sys_rst,
    input logic       rgb_valid,
    input logic       rgb_ready,
    input chan_t      r,
    input chan_t      g,
    input chan_t      b,
    input logic       collision,
    input logic       buf_valid,
    input logic       buf_ready,
    input layer_rec_t buf_rec
);

    // Output held until the sink takes it
    assert property (@(posedge clk) disable iff (sys_rst)
        rgb_valid && !rgb_ready |=> rgb_valid)
        else $error("rgb_valid dropped before rgb_ready");

    assert property (@(posedge clk) disable iff (sys_rst)
        rgb_valid && !rgb_ready |=> $stable({r, g, b, collision}))
        else $error("Output payload changed while stalled");

    assert property (@(posedge clk)
        sys_rst |=> !rgb_valid)
        else $error("rgb_valid high right after reset");

    // Record entering the compositor during blanking
    assert property (@(posedge clk) disable iff (sys_rst)
        buf_valid && buf_ready && !buf_rec.display_on |=>
            ({r, g, b} == 6'd0) && !collision)
        else $error("Blanked pixel is not black");

endmodule

bind goose_render_top goose_render_sva u_sva (
    .clk       (clk),
    .sys_rst   (sys_rst),
    .rgb_valid (rgb_valid),
    .rgb_ready (rgb_ready),
    .r         (r),
    .g         (g),
    .b         (b),
    .collision (collision),
    .buf_valid (buf_valid),
    .buf_ready (buf_ready),
    .buf_rec   (buf_rec)
);

/* source/goose_render_top.sv */
`include "render_defs.svh"

module goose_render_top
    import render_pkg::*;
(
    input  logic       clk,
    input  logic       sys_rst,

    // Pixel stream in
    input  logic       pix_valid,
    output logic       pix_ready,
    input  coord_t     haddr,
    input  coord_t     vaddr,
    input  logic       display_on,

    // Scene state
    input  logic [6:0] jump_pos,
    input  scroll_t    scroll_pos,
    input  logic [1:0] obstacle_select,
    input  logic [1:0] obstacle_type,
    input  logic       game_start_blink,

    // Colour stream out
    output logic       rgb_valid,
    input  logic       rgb_ready,
    output chan_t      r,
    output chan_t      g,
    output chan_t      b,
    output logic       collision
);

    pixel_req_t pix_req;
    logic       lay_valid;
    logic       lay_ready;
    layer_rec_t lay_rec;
    logic       buf_valid;
    logic       buf_ready;
    layer_rec_t buf_rec;
    rgb_t       out_rgb;

    assign pix_req = '{haddr: haddr, vaddr: vaddr, display_on: display_on};

    sprite_layers u_layers (
        .clk              (clk),
        .sys_rst          (sys_rst),
        .in_valid         (pix_valid),
        .in_ready         (pix_ready),
        .in_pix           (pix_req),
        .jump_pos         (jump_pos),
        .scroll_pos       (scroll_pos),
        .obstacle_select  (obstacle_select),
        .obstacle_type    (obstacle_type),
        .game_start_blink (game_start_blink),
        .out_valid        (lay_valid),
        .out_ready        (lay_ready),
        .out_rec          (lay_rec)
    );

    // Absorbs output stalls before they reach the pixel source
    pixel_fifo #(
        .payload_t (layer_rec_t),
        .DEPTH     (`RENDER_FIFO_DEPTH)
    ) u_fifo (
        .clk      (clk),
        .sys_rst  (sys_rst),
        .wr_valid (lay_valid),
        .wr_ready (lay_ready),
        .wr_data  (lay_rec),
        .rd_valid (buf_valid),
        .rd_ready (buf_ready),
        .rd_data  (buf_rec)
    );

    pixel_compositor u_comp (
        .clk           (clk),
        .sys_rst       (sys_rst),
        .in_valid      (buf_valid),
        .in_ready      (buf_ready),
        .in_rec        (buf_rec),
        .out_valid     (rgb_valid),
        .out_ready     (rgb_ready),
        .out_rgb       (out_rgb),
        .out_collision (collision)
    );

    assign r = out_rgb.r;
    assign g = out_rgb.g;
    assign b = out_rgb.b;

endmodule

/* source/pixel_compositor.sv */
`include "render_defs.svh"

module pixel_compositor
    import render_pkg::*;
(
    input  logic       clk,
    input  logic       sys_rst,

    // Layer record stream
    input  logic       in_valid,
    output logic       in_ready,
    input  layer_rec_t in_rec,

    // Colour stream
    output logic       out_valid,
    input  logic       out_ready,
    output rgb_t       out_rgb,
    output logic       out_collision
);

    rgb_t next_rgb;
    logic next_collision;

    // First set layer wins, highest priority first
    always_comb begin
        if (!in_rec.display_on) begin
            next_rgb = `RENDER_COL_BLACK;  // Blanking interval
        end else if (in_rec.mask.goose) begin
            next_rgb = `RENDER_COL_GOOSE;
        end else if (in_rec.mask.ion) begin
            next_rgb = `RENDER_COL_ION;
        end else if (in_rec.mask.uw) begin
            next_rgb = `RENDER_COL_UW;
        end else if (in_rec.mask.ground) begin
            next_rgb = `RENDER_COL_GROUND;
        end else if (in_rec.mask.sky) begin
            next_rgb = `RENDER_COL_SKY;
        end else begin
            next_rgb = `RENDER_COL_BLACK;
        end
    end

    // Goose touching either obstacle
    assign next_collision = in_rec.display_on &&
                            in_rec.mask.goose && (in_rec.mask.ion || in_rec.mask.uw);

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_rgb       <= next_rgb;
            out_collision <= next_collision;
        end
    end

endmodule

/* source/pixel_fifo.sv */
module pixel_fifo
    import render_pkg::*;
#(
    parameter type payload_t = layer_rec_t,
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     sys_rst,

    // Write side
    input  logic     wr_valid,
    output logic     wr_ready,
    input  payload_t wr_data,

    // Read side
    output logic     rd_valid,
    input  logic     rd_ready,
    output payload_t rd_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    assign wr_ready = count != CNT_W'(DEPTH);  // Only full blocks a write
    assign rd_valid = count != '0;
    assign rd_data  = mem[rd_ptr];

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                // Explicit wrap so any depth works
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous read and write leaves the count unchanged
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

/* source/sprite_layers.sv */
`include "render_defs.svh"

module sprite_layers
    import render_pkg::*;
(
    input  logic       clk,
    input  logic       sys_rst,

    // Pixel request stream
    input  logic       in_valid,
    output logic       in_ready,
    input  pixel_req_t in_pix,

    // Scene state, held stable while pixels are in flight
    input  logic [6:0] jump_pos,
    input  scroll_t    scroll_pos,
    input  logic [1:0] obstacle_select,
    input  logic [1:0] obstacle_type,
    input  logic       game_start_blink,

    // Layer record stream
    output logic       out_valid,
    input  logic       out_ready,
    output layer_rec_t out_rec
);

    logic [10:0] hpos;
    logic [10:0] vpos;
    logic [10:0] goose_y;
    logic [11:0] goose_y_end;
    logic [10:0] ion_x;
    logic [11:0] ion_x_end;
    logic [10:0] uw_x;
    logic [11:0] uw_x_end;
    logic [10:0] uw_dx;
    logic [10:0] uw_dy;
    logic        in_ion_box;
    logic        in_uw_box;
    logic        uw_on_edge;
    layer_rec_t  next_rec;

    assign hpos = {1'b0, in_pix.haddr};
    assign vpos = {1'b0, in_pix.vaddr};

    // Goose top row rises with the jump
    assign goose_y     = 11'(`RENDER_GOOSE_Y_BASE) - {4'd0, jump_pos};
    assign goose_y_end = {1'b0, goose_y} + 12'(`RENDER_GOOSE_H);

    // Obstacles move left as the world scrolls, 11-bit wrap
    assign ion_x     = 11'(`RENDER_OBS_START) - scroll_pos;
    assign uw_x      = ion_x + 11'(`RENDER_UW_OFFSET);
    assign ion_x_end = {1'b0, ion_x} + 12'(`RENDER_ION_W);  // Wide so the end never wraps
    assign uw_x_end  = {1'b0, uw_x} + 12'(`RENDER_UW_W);

    assign in_ion_box = (hpos >= ion_x) && ({1'b0, hpos} < ion_x_end) &&
                        (vpos >= 11'(`RENDER_FLOOR_Y - `RENDER_ION_H)) &&
                        (vpos < 11'(`RENDER_FLOOR_Y));

    assign in_uw_box = (hpos >= uw_x) && ({1'b0, hpos} < uw_x_end) &&
                       (vpos >= 11'(`RENDER_FLOOR_Y - `RENDER_UW_H)) &&
                       (vpos < 11'(`RENDER_FLOOR_Y));

    // Position inside the emblem box, only meaningful when in_uw_box
    assign uw_dx = hpos - uw_x;
    assign uw_dy = vpos - 11'(`RENDER_FLOOR_Y - `RENDER_UW_H);

    assign uw_on_edge = (uw_dx < 11'(`RENDER_UW_EDGE)) ||
                        (uw_dx >= 11'(`RENDER_UW_W - `RENDER_UW_EDGE)) ||
                        (uw_dy < 11'(`RENDER_UW_EDGE)) ||
                        (uw_dy >= 11'(`RENDER_UW_H - `RENDER_UW_EDGE));

    always_comb begin
        next_rec = '0;
        next_rec.display_on = in_pix.display_on;
        if (in_pix.display_on) begin
            next_rec.mask.sky    = vpos < 11'(`RENDER_FLOOR_Y);
            next_rec.mask.ground = vpos >= 11'(`RENDER_FLOOR_Y);

            // Goose only drawn while the start blink is on
            next_rec.mask.goose = game_start_blink &&
                                  (hpos >= 11'(`RENDER_GOOSE_X)) &&
                                  (hpos < 11'(`RENDER_GOOSE_X + `RENDER_GOOSE_W)) &&
                                  (vpos >= goose_y) && ({1'b0, vpos} < goose_y_end);

            // Railway is solid, or dashed on every other group of four rows
            if (obstacle_select[0] && in_ion_box) begin
                next_rec.mask.ion = obstacle_type[0] || (in_pix.vaddr[2:0] < 3'd4);
            end

            // Emblem is filled, or only its outline
            if (obstacle_select[1] && in_uw_box) begin
                next_rec.mask.uw = obstacle_type[1] || uw_on_edge;
            end
        end
    end

    // Take a new pixel when the output register is free or draining
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (sys_rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_rec <= next_rec;
        end
    end

endmodule

/* source/render_pkg.sv */
package render_pkg;

    // Screen position, 640x480 fits in ten bits
    typedef logic [9:0] coord_t;

    // World scroll position, wraps at 2048
    typedef logic [10:0] scroll_t;

    // One colour channel of the 6-bit output
    typedef logic [1:0] chan_t;

    typedef struct packed {
        chan_t r;
        chan_t g;
        chan_t b;
    } rgb_t;

    // One flag per scene layer, highest priority first
    typedef struct packed {
        logic goose;
        logic ion;   // Railway obstacle
        logic uw;    // Emblem obstacle
        logic ground;
        logic sky;
    } layer_mask_t;

    // Pixel request entering the renderer
    typedef struct packed {
        coord_t haddr;
        coord_t vaddr;
        logic   display_on;
    } pixel_req_t;

    // Result of the layer test, handed to the compositor
    typedef struct packed {
        layer_mask_t mask;
        logic        display_on;
    } layer_rec_t;

endpackage

/* source/render_defs.svh */
`ifndef RENDER_DEFS_SVH
`define RENDER_DEFS_SVH

// Screen geometry
`define RENDER_FLOOR_Y       240   // First ground row

// Goose box, fixed column, row moves with the jump
`define RENDER_GOOSE_X       50
`define RENDER_GOOSE_W       30
`define RENDER_GOOSE_H       40
`define RENDER_GOOSE_Y_BASE  200   // Top row when standing

// Railway obstacle
`define RENDER_ION_W         20
`define RENDER_ION_H         40

// Emblem obstacle, square with optional outline-only look
`define RENDER_UW_W          30
`define RENDER_UW_H          30
`define RENDER_UW_EDGE       2

// Obstacle placement in world coordinates
`define RENDER_OBS_START     640   // Spawn column, right of the screen
`define RENDER_UW_OFFSET     250   // Emblem trails the railway obstacle

// Layer colours as packed {r, g, b}, two bits each
`define RENDER_COL_GOOSE     6'b11_11_00
`define RENDER_COL_ION       6'b01_01_01
`define RENDER_COL_UW        6'b11_11_11
`define RENDER_COL_GROUND    6'b01_01_01
`define RENDER_COL_SKY       6'b00_11_11
`define RENDER_COL_BLACK     6'b00_00_00

// Layer record buffer between tester and compositor
`define RENDER_FIFO_DEPTH    4

`endif
